// File: list.f
+incdir+src
src/soc_periph_pkg.sv
src/apb_periph_decode.sv
src/apb_gpio.sv
src/apb_timer_unit.sv
src/fc_event_map.sv
src/soc_peripherals.sv
test/soc_periph_assertions.sv
test/tb_soc_peripherals.sv

// File: run.sh
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_soc_peripherals -Mdir "$BUILD_DIR" -o sim_soc_peripherals \
    -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_soc_peripherals" +verilator+error+limit+100 > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG_FILE"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

// File: src/apb_gpio.sv
////////////////////////////////////////
// APB GPIO block
// Direction and output registers, input
// synchronizer, rising-edge interrupts
////////////////////////////////////////

`default_nettype none

`include "soc_periph_config.svh"

module apb_gpio #(
    parameter int NGPIO = `SOC_NGPIO
) (
    input  logic                           clk_i,
    input  logic                           arst_n_i,

    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [7:0]                     paddr_i,
    input  logic [`SOC_APB_DATA_WIDTH-1:0] pwdata_i,
    output logic [`SOC_APB_DATA_WIDTH-1:0] prdata_o,

    input  logic [NGPIO-1:0]               gpio_i,
    output logic [NGPIO-1:0]               gpio_out_o,
    output logic [NGPIO-1:0]               gpio_dir_o,
    output logic                           gpio_irq_o
);

    import soc_periph_pkg::*;

    localparam int PAD_W = `SOC_APB_DATA_WIDTH - NGPIO;

    logic             wr_en;
    logic             rd_en;
    logic [NGPIO-1:0] dir_q;
    logic [NGPIO-1:0] out_q;
    logic [NGPIO-1:0] inten_q;
    logic [NGPIO-1:0] status_q;
    logic [NGPIO-1:0] sync1_q;
    logic [NGPIO-1:0] sync2_q;
    logic [NGPIO-1:0] prev_q;
    logic [NGPIO-1:0] rise;
    logic             irq_q;

    assign wr_en = psel_i && penable_i && pwrite_i;
    assign rd_en = psel_i && penable_i && !pwrite_i;

    // Enabled pins whose synchronized level just went high
    assign rise = sync2_q & ~prev_q & inten_q;

    ////////////////////////////////////////
    // Registers and input path
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            inten_q  <= '0;
            status_q <= '0;
            sync1_q  <= '0;
            sync2_q  <= '0;
            prev_q   <= '0;
            irq_q    <= 1'b0;
        end else begin
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            irq_q   <= |rise;
            if (wr_en) begin
                case (paddr_i)
                    REG_PADDIR: dir_q   <= pwdata_i[NGPIO-1:0];
                    REG_PADOUT: out_q   <= pwdata_i[NGPIO-1:0];
                    REG_INTEN:  inten_q <= pwdata_i[NGPIO-1:0];
                    default: ;
                endcase
            end
            // Clear on read, a new edge in the same cycle still lands
            if (rd_en && paddr_i == REG_INTSTATUS) begin
                status_q <= rise;
            end else begin
                status_q <= status_q | rise;
            end
        end
    end

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////
    always_comb begin
        case (paddr_i)
            REG_PADDIR:    prdata_o = {{PAD_W{1'b0}}, dir_q};
            REG_PADIN:     prdata_o = {{PAD_W{1'b0}}, sync2_q};
            REG_PADOUT:    prdata_o = {{PAD_W{1'b0}}, out_q};
            REG_INTEN:     prdata_o = {{PAD_W{1'b0}}, inten_q};
            REG_INTSTATUS: prdata_o = {{PAD_W{1'b0}}, status_q};
            default:       prdata_o = '0;
        endcase
    end

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign gpio_irq_o = irq_q;

endmodule

`default_nettype wire

// File: src/apb_periph_decode.sv
////////////////////////////////////////
// APB peripheral decoder
// Routes psel by address region, muxes
// read data, flags unmapped accesses
////////////////////////////////////////

`default_nettype none

`include "soc_periph_config.svh"

module apb_periph_decode (
    input  logic                           apb_psel_i,
    input  logic                           apb_penable_i,
    input  logic [`SOC_APB_ADDR_WIDTH-1:0] apb_paddr_i,

    output logic                           gpio_psel_o,
    output logic                           timer_psel_o,

    input  logic [`SOC_APB_DATA_WIDTH-1:0] gpio_prdata_i,
    input  logic [`SOC_APB_DATA_WIDTH-1:0] timer_prdata_i,

    output logic [`SOC_APB_DATA_WIDTH-1:0] apb_prdata_o,
    output logic                           apb_pslverr_o
);

    import soc_periph_pkg::*;

    localparam logic [`SOC_APB_ADDR_WIDTH-1:0] GPIO_BASE  = `SOC_GPIO_BASE;
    localparam logic [`SOC_APB_ADDR_WIDTH-1:0] TIMER_BASE = `SOC_TIMER_BASE;

    periph_sel_e sel;

    // Region compare on the upper address bits
    always_comb begin
        if (apb_paddr_i[`SOC_REGION_BITS] == GPIO_BASE[`SOC_REGION_BITS]) begin
            sel = SEL_GPIO;
        end else if (apb_paddr_i[`SOC_REGION_BITS] == TIMER_BASE[`SOC_REGION_BITS]) begin
            sel = SEL_TIMER;
        end else begin
            sel = SEL_NONE;
        end
    end

    assign gpio_psel_o  = apb_psel_i && (sel == SEL_GPIO);
    assign timer_psel_o = apb_psel_i && (sel == SEL_TIMER);

    // Error only in the access phase of an unmapped transfer
    assign apb_pslverr_o = apb_psel_i && apb_penable_i && (sel == SEL_NONE);

    always_comb begin
        case (sel)
            SEL_GPIO:  apb_prdata_o = gpio_prdata_i;
            SEL_TIMER: apb_prdata_o = timer_prdata_i;
            default:   apb_prdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/apb_timer_unit.sv
////////////////////////////////////////
// APB compare-match timer
// Free-running 32-bit counter that wraps
// on compare and pulses an interrupt
////////////////////////////////////////

`default_nettype none

`include "soc_periph_config.svh"

module apb_timer_unit (
    input  logic                           clk_i,
    input  logic                           arst_n_i,

    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [7:0]                     paddr_i,
    input  logic [`SOC_APB_DATA_WIDTH-1:0] pwdata_i,
    output logic [`SOC_APB_DATA_WIDTH-1:0] prdata_o,

    output logic                           timer_irq_o
);

    import soc_periph_pkg::*;

    logic        wr_en;
    logic        en_q;
    logic [31:0] count_q;
    logic [31:0] cmp_q;
    logic        match;
    logic        irq_q;

    assign wr_en = psel_i && penable_i && pwrite_i;

    // Also catches a compare lowered below the running count
    assign match = en_q && (count_q >= cmp_q);

    ////////////////////////////////////////
    // Control and compare registers
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q  <= 1'b0;
            cmp_q <= '0;
        end else if (wr_en) begin
            case (paddr_i)
                REG_CTRL: en_q  <= pwdata_i[0];
                REG_CMP:  cmp_q <= pwdata_i;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // Counter
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
            irq_q   <= 1'b0;
        end else begin
            irq_q <= match;
            // Software load wins over counting
            if (wr_en && paddr_i == REG_COUNT) begin
                count_q <= pwdata_i;
            end else if (match) begin
                count_q <= '0;
            end else if (en_q) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////
    always_comb begin
        case (paddr_i)
            REG_CTRL:  prdata_o = {31'd0, en_q};
            REG_COUNT: prdata_o = count_q;
            REG_CMP:   prdata_o = cmp_q;
            default:   prdata_o = '0;
        endcase
    end

    // One pulse per wrap, period is cmp+1 cycles
    assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

// File: src/fc_event_map.sv
////////////////////////////////////////
// Fabric-controller event mapper
// Edge events of the slow reference clock
// plus peripheral interrupts, registered
////////////////////////////////////////

`default_nettype none

`include "soc_periph_config.svh"

module fc_event_map (
    input  logic                         clk_i,
    input  logic                         arst_n_i,

    input  logic                         slow_clk_i,
    input  logic                         gpio_irq_i,
    input  logic                         timer_irq_i,

    output logic [`SOC_FC_EVT_WIDTH-1:0] fc_events_o
);

    logic                         ref_sync1_q;
    logic                         ref_sync2_q;
    logic                         ref_prev_q;
    logic                         ref_edge;
    logic [`SOC_FC_EVT_WIDTH-1:0] events_d;
    logic [`SOC_FC_EVT_WIDTH-1:0] events_q;

    // Two-flop synchronizer, then one more stage for edge compare
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ref_sync1_q <= 1'b0;
            ref_sync2_q <= 1'b0;
            ref_prev_q  <= 1'b0;
        end else begin
            ref_sync1_q <= slow_clk_i;
            ref_sync2_q <= ref_sync1_q;
            ref_prev_q  <= ref_sync2_q;
        end
    end

    // Rising and falling edges share one event line
    assign ref_edge = ref_sync2_q ^ ref_prev_q;

    always_comb begin
        events_d                    = '0;
        events_d[`SOC_FC_EVT_TIMER] = timer_irq_i;
        events_d[`SOC_FC_EVT_REF]   = ref_edge;
        events_d[`SOC_FC_EVT_GPIO]  = gpio_irq_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            events_q <= '0;
        end else begin
            events_q <= events_d;
        end
    end

    assign fc_events_o = events_q;

endmodule

`default_nettype wire

// File: src/soc_periph_config.svh
////////////////////////////////////////
// Peripheral subsystem configuration
// Bus widths, address map, GPIO count
// and fabric-controller event positions
////////////////////////////////////////

`ifndef SOC_PERIPH_CONFIG_SVH
`define SOC_PERIPH_CONFIG_SVH

`define SOC_APB_ADDR_WIDTH 12
`define SOC_APB_DATA_WIDTH 32
`define SOC_NGPIO          8

// Each peripheral owns one 256-byte region
`define SOC_GPIO_BASE      12'h000
`define SOC_TIMER_BASE     12'h100
`define SOC_REGION_BITS    `SOC_APB_ADDR_WIDTH-1:8

`define SOC_FC_EVT_TIMER   10
`define SOC_FC_EVT_REF     14
`define SOC_FC_EVT_GPIO    15
`define SOC_FC_EVT_WIDTH   32

`endif

// File: src/soc_periph_pkg.sv
////////////////////////////////////////
// Peripheral subsystem types
// Decoder targets and register offsets
////////////////////////////////////////

`default_nettype none

package soc_periph_pkg;

    // Slave selected by the address decoder
    typedef enum logic [1:0] {
        SEL_GPIO  = 2'd0,
        SEL_TIMER = 2'd1,
        SEL_NONE  = 2'd2
    } periph_sel_e;

    // GPIO register map, byte offsets
    typedef enum logic [7:0] {
        REG_PADDIR    = 8'h00,
        REG_PADIN     = 8'h04,
        REG_PADOUT    = 8'h08,
        REG_INTEN     = 8'h0C,
        REG_INTSTATUS = 8'h10
    } gpio_reg_e;

    // Timer register map, byte offsets
    typedef enum logic [7:0] {
        REG_CTRL  = 8'h00,
        REG_COUNT = 8'h04,
        REG_CMP   = 8'h08
    } timer_reg_e;

endpackage

`default_nettype wire

// File: src/soc_peripherals.sv
////////////////////////////////////////
// SoC peripheral subsystem top
// APB decoder, GPIO, timer and the
// fabric-controller event vector
////////////////////////////////////////

`default_nettype none

`include "soc_periph_config.svh"

module soc_peripherals (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           slow_clk_i,

    // APB slave port
    input  logic                           apb_psel_i,
    input  logic                           apb_penable_i,
    input  logic                           apb_pwrite_i,
    input  logic [`SOC_APB_ADDR_WIDTH-1:0] apb_paddr_i,
    input  logic [`SOC_APB_DATA_WIDTH-1:0] apb_pwdata_i,
    output logic [`SOC_APB_DATA_WIDTH-1:0] apb_prdata_o,
    output logic                           apb_pready_o,
    output logic                           apb_pslverr_o,

    input  logic [`SOC_NGPIO-1:0]          gpio_i,
    output logic [`SOC_NGPIO-1:0]          gpio_out_o,
    output logic [`SOC_NGPIO-1:0]          gpio_dir_o,

    output logic [`SOC_FC_EVT_WIDTH-1:0]   fc_events_o
);

    logic                           gpio_psel;
    logic                           timer_psel;
    logic [`SOC_APB_DATA_WIDTH-1:0] gpio_prdata;
    logic [`SOC_APB_DATA_WIDTH-1:0] timer_prdata;
    logic                           gpio_irq;
    logic                           timer_irq;

    // No wait states on any slave
    assign apb_pready_o = 1'b1;

    ////////////////////////////////////////
    // Peripheral bus
    ////////////////////////////////////////
    apb_periph_decode i_decode (
        .apb_psel_i     ( apb_psel_i    ),
        .apb_penable_i  ( apb_penable_i ),
        .apb_paddr_i    ( apb_paddr_i   ),
        .gpio_psel_o    ( gpio_psel     ),
        .timer_psel_o   ( timer_psel    ),
        .gpio_prdata_i  ( gpio_prdata   ),
        .timer_prdata_i ( timer_prdata  ),
        .apb_prdata_o   ( apb_prdata_o  ),
        .apb_pslverr_o  ( apb_pslverr_o )
    );

    ////////////////////////////////////////
    // Slaves
    ////////////////////////////////////////
    apb_gpio #(
        .NGPIO ( `SOC_NGPIO )
    ) i_apb_gpio (
        .clk_i      ( clk_i            ),
        .arst_n_i   ( arst_n_i         ),
        .psel_i     ( gpio_psel        ),
        .penable_i  ( apb_penable_i    ),
        .pwrite_i   ( apb_pwrite_i     ),
        .paddr_i    ( apb_paddr_i[7:0] ),
        .pwdata_i   ( apb_pwdata_i     ),
        .prdata_o   ( gpio_prdata      ),
        .gpio_i     ( gpio_i           ),
        .gpio_out_o ( gpio_out_o       ),
        .gpio_dir_o ( gpio_dir_o       ),
        .gpio_irq_o ( gpio_irq         )
    );

    apb_timer_unit i_apb_timer_unit (
        .clk_i       ( clk_i            ),
        .arst_n_i    ( arst_n_i         ),
        .psel_i      ( timer_psel       ),
        .penable_i   ( apb_penable_i    ),
        .pwrite_i    ( apb_pwrite_i     ),
        .paddr_i     ( apb_paddr_i[7:0] ),
        .pwdata_i    ( apb_pwdata_i     ),
        .prdata_o    ( timer_prdata     ),
        .timer_irq_o ( timer_irq        )
    );

    ////////////////////////////////////////
    // Event vector
    ////////////////////////////////////////
    fc_event_map i_fc_event_map (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .slow_clk_i  ( slow_clk_i  ),
        .gpio_irq_i  ( gpio_irq    ),
        .timer_irq_i ( timer_irq   ),
        .fc_events_o ( fc_events_o )
    );

endmodule

`default_nettype wire

// File: test/soc_periph_assertions.sv
////////////////////////////////////////
// APB and event-vector checks
// Bound into the subsystem top
////////////////////////////////////////

`default_nettype none

`include "soc_periph_config.svh"

module soc_periph_assertions (
    input logic                         clk_i,
    input logic                         arst_n_i,
    input logic                         apb_psel_i,
    input logic                         apb_penable_i,
    input logic                         apb_pslverr_i,
    input logic                         gpio_psel_i,
    input logic                         timer_psel_i,
    input logic [`SOC_FC_EVT_WIDTH-1:0] fc_events_i
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [`SOC_FC_EVT_WIDTH-1:0] USED_BITS =
        (32'd1 << `SOC_FC_EVT_TIMER) | (32'd1 << `SOC_FC_EVT_REF) | (32'd1 << `SOC_FC_EVT_GPIO);

    int fail_pslverr = 0;
    int fail_psel = 0;
    int fail_rsv = 0;

    // Slave error only in an access phase that follows a setup cycle
    pslverr_in_access: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        apb_pslverr_i |-> (apb_psel_i && apb_penable_i
                           && $past(apb_psel_i && !apb_penable_i)))
    else begin
        $error("pslverr raised outside an APB access phase");
        fail_pslverr++;
    end

    // Decoder never selects both slaves
    one_slave_selected: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(gpio_psel_i && timer_psel_i))
    else begin
        $error("psel routed to more than one slave");
        fail_psel++;
    end

    reserved_events_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (fc_events_i & ~USED_BITS) == '0)
    else begin
        $error("reserved event bits are set");
        fail_rsv++;
    end

endmodule

bind soc_peripherals soc_periph_assertions i_periph_sva (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .apb_psel_i    ( apb_psel_i    ),
    .apb_penable_i ( apb_penable_i ),
    .apb_pslverr_i ( apb_pslverr_o ),
    .gpio_psel_i   ( gpio_psel     ),
    .timer_psel_i  ( timer_psel    ),
    .fc_events_i   ( fc_events_o   )
);

`default_nettype wire

// File: test/tb_soc_peripherals.sv
////////////////////////////////////////
// Testbench for the peripheral subsystem
// Random APB traffic against a register
// model, GPIO, timer and event checks
////////////////////////////////////////

`default_nettype none

`include "soc_periph_config.svh"

module tb_soc_peripherals;

    timeunit 1ns;
    timeprecision 1ps;

    import soc_periph_pkg::*;

    localparam logic [11:0] GPIO_BASE  = `SOC_GPIO_BASE;
    localparam logic [11:0] TIMER_BASE = `SOC_TIMER_BASE;
    localparam logic [31:0] EVT_TIMER  = 32'd1 << `SOC_FC_EVT_TIMER;
    localparam logic [31:0] EVT_REF    = 32'd1 << `SOC_FC_EVT_REF;
    localparam logic [31:0] EVT_GPIO   = 32'd1 << `SOC_FC_EVT_GPIO;
    localparam logic [31:0] EVT_RSV    = ~(EVT_TIMER | EVT_REF | EVT_GPIO);
    localparam int          TIMEOUT    = 64;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        slow_clk;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [7:0]  gpio_in;
    logic [7:0]  gpio_out;
    logic [7:0]  gpio_dir;
    logic [31:0] fc_events;

    logic [31:0] lfsr = 32'h6b67;
    int          checks = 0;
    int          errors = 0;
    int          rsv_errors = 0;
    int          timeouts = 0;
    logic        last_slverr = 1'b0;

    // Register model
    logic [7:0]  dir_m = '0;
    logic [7:0]  out_m = '0;
    logic [7:0]  inten_m = '0;
    logic [31:0] cmp_m = '0;
    logic [31:0] count_m = '0;
    logic        en_m = 1'b0;

    soc_peripherals uut (
        .clk_i         ( clk       ),
        .arst_n_i      ( arst_n    ),
        .slow_clk_i    ( slow_clk  ),
        .apb_psel_i    ( psel      ),
        .apb_penable_i ( penable   ),
        .apb_pwrite_i  ( pwrite    ),
        .apb_paddr_i   ( paddr     ),
        .apb_pwdata_i  ( pwdata    ),
        .apb_prdata_o  ( prdata    ),
        .apb_pready_o  ( pready    ),
        .apb_pslverr_o ( pslverr   ),
        .gpio_i        ( gpio_in   ),
        .gpio_out_o    ( gpio_out  ),
        .gpio_dir_o    ( gpio_dir  ),
        .fc_events_o   ( fc_events )
    );

    always #10 clk = ~clk;

    // Reserved event bits must never rise
    always @(negedge clk) begin
        if (arst_n) begin
            assert ((fc_events & EVT_RSV) == 32'd0) else begin
                rsv_errors++;
                $display("Error: fc_events_o reserved bits set, value %h", fc_events);
            end
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr[0]};
            if (lfsr[0]) begin
                lfsr = (lfsr >> 1) ^ 32'h80200003;
            end else begin
                lfsr = lfsr >> 1;
            end
        end
        return val;
    endfunction

    function automatic logic [11:0] gpio_addr(input logic [7:0] off);
        return GPIO_BASE | {4'h0, off};
    endfunction

    function automatic logic [11:0] timer_addr(input logic [7:0] off);
        return TIMER_BASE | {4'h0, off};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    // Setup then access phase, sampled mid-cycle
    task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int wait_cnt;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        wait_cnt = 0;
        while (!pready && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!pready) begin
            timeouts++;
            $display("Timeout: APB slave never became ready at address %h", addr);
        end
        rdata       = prdata;
        last_slverr = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
        apb_transfer(1'b0, addr, 32'd0, data);
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] data;
        read_reg(addr, data);
        check_val(name, data, exp);
        check_val("apb_pslverr_o", {31'd0, last_slverr}, 32'd0);
    endtask

    // Steps at least one cycle, so a pulse already seen is not seen again
    task automatic wait_event(input logic [31:0] mask, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while ((fc_events & mask) == 32'd0 && cycles < TIMEOUT);
        if ((fc_events & mask) == 32'd0) begin
            timeouts++;
            $display("Timeout: no pulse on fc_events_o with mask %h", mask);
        end
    endtask

    task automatic count_pulses(input logic [31:0] mask, input int window, output int n);
        n = 0;
        for (int i = 0; i < window; i++) begin
            @(negedge clk);
            if ((fc_events & mask) != 32'd0) begin
                n++;
            end
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        logic [31:0] rnd;
        logic [31:0] rd;
        logic [11:0] addr;
        logic [7:0]  pins;
        logic [7:0]  exp_st;
        int          cycles;
        int          n;
        int          sva_fails;

        arst_n   <= 1'b0;
        slow_clk <= 1'b0;
        psel     <= 1'b0;
        penable  <= 1'b0;
        pwrite   <= 1'b0;
        paddr    <= '0;
        pwdata   <= '0;
        gpio_in  <= '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);

        // Reset values
        check_val("fc_events_o", fc_events, 32'd0);
        check_val("gpio_out_o", {24'd0, gpio_out}, 32'd0);
        check_val("gpio_dir_o", {24'd0, gpio_dir}, 32'd0);
        check_val("apb_pslverr_o", {31'd0, pslverr}, 32'd0);
        read_check(timer_addr(REG_CTRL), 32'd0, "CTRL after reset");
        read_check(timer_addr(REG_COUNT), 32'd0, "COUNT after reset");
        read_check(timer_addr(REG_CMP), 32'd0, "CMP after reset");

        // Direction and output registers
        for (int i = 0; i < 8; i++) begin
            rnd = next_bits(8);
            dir_m = rnd[7:0];
            rnd = next_bits(8);
            out_m = rnd[7:0];
            write_reg(gpio_addr(REG_PADDIR), {24'd0, dir_m});
            write_reg(gpio_addr(REG_PADOUT), {24'd0, out_m});
            @(negedge clk);
            check_val("gpio_dir_o", {24'd0, gpio_dir}, {24'd0, dir_m});
            check_val("gpio_out_o", {24'd0, gpio_out}, {24'd0, out_m});
            read_check(gpio_addr(REG_PADDIR), {24'd0, dir_m}, "PADDIR readback");
            read_check(gpio_addr(REG_PADOUT), {24'd0, out_m}, "PADOUT readback");
        end

        // Pin levels through the synchronizer
        for (int i = 0; i < 8; i++) begin
            rnd = next_bits(8);
            @(posedge clk);
            gpio_in <= rnd[7:0];
            repeat (4) @(posedge clk);
            read_check(gpio_addr(REG_PADIN), {24'd0, rnd[7:0]}, "PADIN readback");
        end

        // Rising-edge interrupts, odd rounds use disabled pins only
        @(posedge clk);
        gpio_in <= '0;
        repeat (4) @(posedge clk);
        read_reg(gpio_addr(REG_INTSTATUS), rd);
        for (int i = 0; i < 6; i++) begin
            rnd = next_bits(8);
            inten_m = rnd[7:0] | 8'h01;
            write_reg(gpio_addr(REG_INTEN), {24'd0, inten_m});
            rnd = next_bits(8);
            pins = (i % 2 == 1) ? (rnd[7:0] & ~inten_m) : rnd[7:0];
            exp_st = pins & inten_m;
            @(posedge clk);
            gpio_in <= pins;
            if (exp_st != 8'h00) begin
                wait_event(EVT_GPIO, cycles);
                count_pulses(EVT_GPIO, 8, n);
            end else begin
                count_pulses(EVT_GPIO, 12, n);
            end
            check_val("fc_events_o[15] extra pulses", n, 32'd0);
            read_check(gpio_addr(REG_INTSTATUS), {24'd0, exp_st}, "INTSTATUS");
            read_check(gpio_addr(REG_INTSTATUS), 32'd0, "INTSTATUS second read");
            @(posedge clk);
            gpio_in <= '0;
            repeat (4) @(posedge clk);
        end
        inten_m = '0;
        write_reg(gpio_addr(REG_INTEN), 32'd0);

        // Compare-match timer
        for (int k = 0; k < 3; k++) begin
            rnd = next_bits(5);
            cmp_m = 32'd2 + (rnd % 32'd19);
            en_m = 1'b0;
            write_reg(timer_addr(REG_CTRL), 32'd0);
            write_reg(timer_addr(REG_COUNT), 32'd0);
            write_reg(timer_addr(REG_CMP), cmp_m);
            read_check(timer_addr(REG_CMP), cmp_m, "CMP readback");
            en_m = 1'b1;
            write_reg(timer_addr(REG_CTRL), 32'd1);
            wait_event(EVT_TIMER, cycles);
            for (int j = 0; j < 3; j++) begin
                wait_event(EVT_TIMER, cycles);
                check_val("fc_events_o[10] period", cycles, cmp_m + 32'd1);
            end
            for (int j = 0; j < 4; j++) begin
                read_reg(timer_addr(REG_COUNT), rd);
                checks++;
                assert (rd <= cmp_m) else begin
                    errors++;
                    $display("Error: REG_COUNT is %h, above compare %h", rd, cmp_m);
                end
            end
            read_check(timer_addr(REG_CTRL), {31'd0, en_m}, "CTRL readback");
        end
        en_m = 1'b0;
        write_reg(timer_addr(REG_CTRL), 32'd0);
        count_m = next_bits(16);
        write_reg(timer_addr(REG_COUNT), count_m);
        read_check(timer_addr(REG_COUNT), count_m, "COUNT load");

        // Reference clock edges
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            slow_clk <= ~slow_clk;
            wait_event(EVT_REF, cycles);
            rnd = next_bits(3);
            count_pulses(EVT_REF, 4 + int'(rnd[2:0]), n);
            check_val("fc_events_o[14] extra pulses", n, 32'd0);
        end

        // Unmapped regions
        for (int i = 0; i < 10; i++) begin
            rnd = next_bits(4);
            addr = {rnd[3:0], 8'h00};
            if (addr[11:8] < 4'd2) begin
                addr[11:8] = addr[11:8] + 4'd2;
            end
            rnd = next_bits(8);
            addr[7:0] = {rnd[7:2], 2'b00};
            rnd = next_bits(1);
            if (rnd[0]) begin
                rd = next_bits(32);
                write_reg(addr, rd);
            end else begin
                read_reg(addr, rd);
                check_val("apb_prdata_o unmapped", rd, 32'd0);
            end
            check_val("apb_pslverr_o unmapped", {31'd0, last_slverr}, 32'd1);
        end
        read_check(gpio_addr(REG_PADDIR), {24'd0, dir_m}, "PADDIR after unmapped");
        read_check(gpio_addr(REG_PADOUT), {24'd0, out_m}, "PADOUT after unmapped");
        read_check(gpio_addr(REG_INTEN), {24'd0, inten_m}, "INTEN after unmapped");
        read_check(timer_addr(REG_CTRL), {31'd0, en_m}, "CTRL after unmapped");
        read_check(timer_addr(REG_CMP), cmp_m, "CMP after unmapped");
        read_check(timer_addr(REG_COUNT), count_m, "COUNT after unmapped");

        repeat (4) @(posedge clk);
        sva_fails = uut.i_periph_sva.fail_pslverr + uut.i_periph_sva.fail_psel
                  + uut.i_periph_sva.fail_rsv;
        $display("Checks: %0d, errors: %0d, reserved-bit errors: %0d, timeouts: %0d, %s %0d",
                 checks, errors, rsv_errors, timeouts, "assertion failures:", sva_fails);
        if (errors + rsv_errors + timeouts + sva_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
